//--- backup_ram_sequencer.sv
`timescale 1ns/100ps

module backup_ram_sequencer (
	input  logic                               clk_sys,
	input  logic                               RESET,
	input  logic                               cart_download,
	input  logic                               cart_start,
	input  logic                               cart_end,
	input  logic [snes_loader_pkg::MASK_W-1:0] ram_mask,
	input  logic                               img_mounted,
	input  logic                               img_readonly,
	input  logic [63:0]                        img_size,
	input  logic                               bk_load_req,
	input  logic                               bk_save_req,
	input  logic                               autosave,
	input  logic                               osd_status,
	input  logic                               bsram_write,
	input  logic                               sd_ack,
	output logic [snes_loader_pkg::LBA_W-1:0]  sd_lba,
	output logic                               sd_rd,
	output logic                               sd_wr,
	output logic                               bk_ena,
	output logic                               bk_loading,
	output logic                               bk_pending
);
	import snes_loader_pkg::*;

	bk_state_e        state;
	logic             old_load;
	logic             old_save;
	logic             old_ack;
	logic             save_req;
	logic             load_edge;
	logic             save_edge;
	logic [LBA_W-1:0] last_lba;

	// Menu opening with unsaved writes counts as a save request
	assign save_req  = bk_save_req | (autosave & bk_pending & osd_status);
	assign load_edge = bk_ena & bk_load_req & ~old_load;
	assign save_edge = bk_ena & save_req & ~old_save;

	// One sector is 512 bytes
	assign last_lba   = LBA_W'(ram_mask[MASK_W-1:9]);
	assign bk_loading = (state == st_loading);

	// ==============================
	// Enable and pending flags
	// ==============================
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			bk_ena     <= 1'b0;
			bk_pending <= 1'b0;
		end else begin
			if (cart_start) begin
				bk_ena <= 1'b0;
			end
			// Save image is mounted by the time the download runs
			if (cart_download && img_mounted && !img_readonly) begin
				bk_ena <= |ram_mask;
			end

			if (bk_ena && !osd_status && bsram_write) begin
				bk_pending <= 1'b1;
			end else if (state != st_idle) begin
				bk_pending <= 1'b0;
			end
		end
	end

	// ==============================
	// Sector transfer
	// ==============================
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			state    <= st_idle;
			sd_rd    <= 1'b0;
			sd_wr    <= 1'b0;
			old_load <= 1'b0;
			old_save <= 1'b0;
			old_ack  <= 1'b0;
		end else begin
			old_load <= bk_load_req;
			old_save <= save_req;
			old_ack  <= sd_ack;

			if (!old_ack && sd_ack) begin
				sd_rd <= 1'b0;
				sd_wr <= 1'b0;
			end

			if (state == st_idle) begin
				if (load_edge || save_edge) begin
					state  <= load_edge ? st_loading : st_saving;
					sd_lba <= '0;
					sd_rd  <= load_edge;
					sd_wr  <= ~load_edge;
				end
				if (cart_end && bk_ena && |img_size) begin
					state  <= st_loading;
					sd_lba <= '0;
					sd_rd  <= 1'b1;
					sd_wr  <= 1'b0;
				end
			end else if (old_ack && !sd_ack) begin
				// Next sector starts once the disk side releases ack
				if (sd_lba >= last_lba) begin
					state <= st_idle;
				end else begin
					sd_lba <= sd_lba + 1'b1;
					sd_rd  <= (state == st_loading);
					sd_wr  <= (state == st_saving);
				end
			end
		end
	end

endmodule

//--- cheat_code_assembler.sv
`timescale 1ns/100ps

module cheat_code_assembler (
	input  logic        clk_sys,
	input  logic        RESET,
	input  logic        code_download,
	input  logic        ioctl_wr,
	input  logic [3:0]  ioctl_addr,
	input  logic [15:0] ioctl_dout,
	output logic [31:0] code_flags,
	output logic [31:0] code_addr,
	output logic [31:0] code_compare,
	output logic [31:0] code_replace,
	output logic        code_strobe
);

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			code_strobe <= 1'b0;
		end else begin
			code_strobe <= code_download & ioctl_wr & (ioctl_addr == 4'd14);
		end
	end

	// Record layout is flags, address, compare, replace
	// Each field arrives low half first
	always_ff @(posedge clk_sys) begin
		if (code_download && ioctl_wr) begin
			case (ioctl_addr)
				4'd0:  code_flags[15:0]    <= ioctl_dout;
				4'd2:  code_flags[31:16]   <= ioctl_dout;
				4'd4:  code_addr[15:0]     <= ioctl_dout;
				4'd6:  code_addr[31:16]    <= ioctl_dout;
				4'd8:  code_compare[15:0]  <= ioctl_dout;
				4'd10: code_compare[31:16] <= ioctl_dout;
				4'd12: code_replace[15:0]  <= ioctl_dout;
				4'd14: code_replace[31:16] <= ioctl_dout;
				default: ;
			endcase
		end
	end

endmodule

//--- download_decoder.sv
`timescale 1ns/100ps

module download_decoder (
	input  logic                                   clk_sys,
	input  logic                                   RESET,
	input  logic                                   ioctl_download,
	input  logic [7:0]                             ioctl_index,
	input  logic [snes_loader_pkg::IOCTL_ADDR_W-1:0] ioctl_addr,
	input  logic [snes_loader_pkg::IOCTL_DATA_W-1:0] ioctl_dout,
	input  logic                                   ioctl_wr,
	input  snes_loader_pkg::header_mode_e          header_mode,
	input  snes_loader_pkg::region_e               region_select,
	output logic                                   cart_download,
	output logic                                   code_download,
	output logic                                   cart_start,
	output logic                                   cart_end,
	output logic [7:0]                             rom_type,
	output logic [snes_loader_pkg::MASK_W-1:0]     rom_mask,
	output logic [snes_loader_pkg::MASK_W-1:0]     ram_mask,
	output logic                                   pal
);
	import snes_loader_pkg::*;

	logic                    cart_download_d;
	logic [3:0]              rom_size;
	logic [3:0]              ram_size;
	logic                    rom_region;
	logic                    forced_map;
	logic [IOCTL_ADDR_W-1:0] info_addr;

	// Index of all ones marks a cheat file
	assign code_download = ioctl_download & (&ioctl_index);
	assign cart_download = ioctl_download & ~(&ioctl_index);

	assign cart_start = cart_download & ~cart_download_d;
	assign cart_end   = ~cart_download & cart_download_d;

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			cart_download_d <= 1'b0;
		end else begin
			cart_download_d <= cart_download;
		end
	end

	// Location of the size fields in the image for forced mappings
	always_comb begin
		forced_map = 1'b1;
		case (header_mode)
			hdr_lorom:   info_addr = LOROM_INFO + HEADER_SKIP;
			hdr_hirom:   info_addr = HIROM_INFO + HEADER_SKIP;
			hdr_exhirom: info_addr = EXHIROM_INFO + HEADER_SKIP;
			default: begin
				info_addr  = '0;
				forced_map = 1'b0;
			end
		endcase
	end

	// ==============================
	// Header parse
	// ==============================
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			rom_region <= 1'b0;
			pal        <= 1'b0;
		end else if (cart_download) begin
			if (ioctl_wr) begin
				if (ioctl_addr == '0) begin
					rom_size <= DEFAULT_ROM_SIZE;
					ram_size <= 4'h0;
					// Auto mode trusts the packed size byte of the loader
					if (header_mode == hdr_auto && ioctl_dout[7:0] != 8'h00) begin
						ram_size <= ioctl_dout[7:4];
						rom_size <= ioctl_dout[3:0];
					end
					case (header_mode)
						hdr_no_header: rom_type <= 8'd0;
						hdr_lorom:     rom_type <= 8'd0;
						hdr_hirom:     rom_type <= 8'd1;
						hdr_exhirom:   rom_type <= 8'd2;
						default:       rom_type <= ioctl_dout[15:8];
					endcase
				end

				if (ioctl_addr == IOCTL_ADDR_W'(2)) begin
					rom_region <= ioctl_dout[8];
				end

				if (forced_map) begin
					if (ioctl_addr == info_addr) begin
						rom_size <= ioctl_dout[11:8];
					end
					if (ioctl_addr == info_addr + IOCTL_ADDR_W'(2)) begin
						ram_size <= ioctl_dout[3:0];
					end
				end

				// Uses the sizes held before this write
				rom_mask <= (MASK_W'(1024) << rom_size) - 1'b1;
				ram_mask <= (ram_size != 4'h0) ? (MASK_W'(1024) << ram_size) - 1'b1 : '0;
			end
		end else begin
			pal <= (region_select == region_auto) ? rom_region : (region_select == region_pal);
		end
	end

endmodule

//--- ram_clear_fill.sv
`timescale 1ns/100ps

module ram_clear_fill #(
	parameter int FILL_BITS = 17
) (
	input  logic                          clk_sys,
	input  logic                          RESET,
	input  logic                          cart_start,
	input  snes_loader_pkg::fill_pattern_e fill_pattern,
	output logic [FILL_BITS-1:0]          fill_addr,
	output logic [7:0]                    fill_data,
	output logic                          fill_wr
);
	import snes_loader_pkg::*;

	// ==============================
	// Sweep counter
	// ==============================
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			fill_wr   <= 1'b0;
			fill_addr <= '0;
		end else if (cart_start) begin
			fill_wr   <= 1'b1;
			fill_addr <= '0;
		end else if (fill_wr) begin
			// Counter wraps back to zero on the last write
			fill_addr <= fill_addr + 1'b1;
			if (&fill_addr) begin
				fill_wr <= 1'b0;
			end
		end
	end

	// Power-on patterns seen on different console revisions
	always_comb begin
		case (fill_pattern)
			fill_snes1:   fill_data = (fill_addr[9] ^ fill_addr[0]) ? 8'hFF : 8'h00;
			fill_snes2:   fill_data = (fill_addr[8] ^ fill_addr[2]) ? 8'h66 : 8'h99;
			fill_sd2snes: fill_data = 8'h55;
			default:      fill_data = 8'hFF;
		endcase
	end

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module snes_loader_tb \
	-f snes_loader.f -o snes_loader_sim
./obj_dir/snes_loader_sim 2>&1 | tee sim.log

if grep -q "SIMULATION FAILED" sim.log; then
	echo "run_sim: simulation reported failure"
	exit 1
fi
if ! grep -q "SIMULATION PASSED" sim.log; then
	echo "run_sim: simulation did not complete"
	exit 1
fi
echo "run_sim: simulation passed"

//--- snes_loader.f
snes_loader_pkg.sv
download_decoder.sv
ram_clear_fill.sv
cheat_code_assembler.sv
backup_ram_sequencer.sv
snes_loader_top.sv
snes_loader_assert.sv
snes_loader_tb.sv

//--- snes_loader_assert.sv
`timescale 1ns/100ps

module snes_loader_assert (
	input logic clk_sys,
	input logic RESET,
	input logic sd_rd,
	input logic sd_wr,
	input logic sd_ack,
	input logic code_strobe,
	input logic fill_wr,
	input logic system_reset
);

	int failures = 0;

	// ==============================
	// Sector handshake
	// ==============================
	request_exclusive: assert property (@(posedge clk_sys) disable iff (RESET)
		!(sd_rd && sd_wr))
		else begin
			failures++;
			$error("sd_rd and sd_wr are high together");
		end

	request_drops_after_ack: assert property (@(posedge clk_sys) disable iff (RESET)
		$rose(sd_ack) |=> !sd_rd && !sd_wr)
		else begin
			failures++;
			$error("sector request still high one cycle after sd_ack rose");
		end

	// Strobe is a single cycle pulse
	strobe_single: assert property (@(posedge clk_sys) disable iff (RESET)
		code_strobe |=> !code_strobe)
		else begin
			failures++;
			$error("code_strobe high for two cycles in a row");
		end

	fill_holds_reset: assert property (@(posedge clk_sys) disable iff (RESET)
		fill_wr |-> system_reset)
		else begin
			failures++;
			$error("fill_wr high without system_reset");
		end

	outputs_low_after_reset: assert property (@(posedge clk_sys)
		RESET |=> !sd_rd && !sd_wr && !fill_wr)
		else begin
			failures++;
			$error("request or fill output high in the cycle after reset");
		end

endmodule

bind snes_loader_top snes_loader_assert snes_loader_assert_inst (
	.clk_sys      (clk_sys),
	.RESET        (RESET),
	.sd_rd        (sd_rd),
	.sd_wr        (sd_wr),
	.sd_ack       (sd_ack),
	.code_strobe  (code_strobe),
	.fill_wr      (fill_wr),
	.system_reset (system_reset)
);

//--- snes_loader_pkg.sv
package snes_loader_pkg;

	// ==============================
	// Download and mask widths
	// ==============================
	localparam int IOCTL_ADDR_W = 25;
	localparam int IOCTL_DATA_W = 16;
	localparam int MASK_W       = 24;
	localparam int LBA_W        = 32;

	// Copier header that precedes the ROM image
	localparam logic [IOCTL_ADDR_W-1:0] HEADER_SKIP = 25'h200;

	// Offsets of the ROM size field with RAM size 2 bytes higher
	localparam logic [IOCTL_ADDR_W-1:0] LOROM_INFO   = 25'h007FD6;
	localparam logic [IOCTL_ADDR_W-1:0] HIROM_INFO   = 25'h00FFD6;
	localparam logic [IOCTL_ADDR_W-1:0] EXHIROM_INFO = 25'h40FFD6;

	localparam logic [3:0] DEFAULT_ROM_SIZE = 4'hC;

	// ==============================
	// Menu selections
	// ==============================
	typedef enum logic [2:0] {
		hdr_auto      = 3'd0,
		hdr_no_header = 3'd1,
		hdr_lorom     = 3'd2,
		hdr_hirom     = 3'd3,
		hdr_exhirom   = 3'd4
	} header_mode_e;

	typedef enum logic [1:0] {
		region_auto = 2'd0,
		region_ntsc = 2'd1,
		region_pal  = 2'd2
	} region_e;

	// Work RAM power-on contents
	typedef enum logic [1:0] {
		fill_snes1    = 2'd0,
		fill_snes2    = 2'd1,
		fill_sd2snes  = 2'd2,
		fill_all_ones = 2'd3
	} fill_pattern_e;

	typedef enum logic [1:0] {
		st_idle    = 2'd0,
		st_loading = 2'd1,
		st_saving  = 2'd2
	} bk_state_e;

endpackage

//--- snes_loader_tb.sv
`timescale 1ns/100ps

module snes_loader_tb;
	import snes_loader_pkg::*;

	localparam int FILL_BITS  = 10;
	localparam int FILL_WORDS = 1 << FILL_BITS;
	localparam int RAM_CODE   = 1;

	// Selectors for the wait loop
	localparam int SIG_FILL    = 0;
	localparam int SIG_REQ     = 1;
	localparam int SIG_STROBE  = 2;
	localparam int SIG_LOADING = 3;

	logic                    clk_sys;
	logic                    RESET;
	logic                    ioctl_download;
	logic [7:0]              ioctl_index;
	logic [IOCTL_ADDR_W-1:0] ioctl_addr;
	logic [IOCTL_DATA_W-1:0] ioctl_dout;
	logic                    ioctl_wr;
	header_mode_e            header_mode;
	region_e                 region_select;
	fill_pattern_e           fill_pattern;
	logic                    img_mounted;
	logic                    img_readonly;
	logic [63:0]             img_size;
	logic                    bk_load_req;
	logic                    bk_save_req;
	logic                    autosave;
	logic                    osd_status;
	logic                    bsram_write;
	logic                    sd_ack;
	logic [7:0]              rom_type;
	logic [MASK_W-1:0]       rom_mask;
	logic [MASK_W-1:0]       ram_mask;
	logic                    pal;
	logic [FILL_BITS-1:0]    fill_addr;
	logic [7:0]              fill_data;
	logic                    fill_wr;
	logic [31:0]             code_flags;
	logic [31:0]             code_addr;
	logic [31:0]             code_compare;
	logic [31:0]             code_replace;
	logic                    code_strobe;
	logic [LBA_W-1:0]        sd_lba;
	logic                    sd_rd;
	logic                    sd_wr;
	logic                    bk_ena;
	logic                    bk_loading;
	logic                    bk_pending;
	logic                    system_reset;

	integer      seed;
	logic [15:0] cheat_word [8];
	int          bound_failures;

	snes_loader_top #(
		.FILL_BITS (FILL_BITS)
	) snes_loader_top_inst (.*);

	// Failed assertions counted by the bound protocol checker
	assign bound_failures = snes_loader_top_inst.snes_loader_assert_inst.failures;

	initial begin
		clk_sys = 1'b0;
		forever #20 clk_sys = ~clk_sys;
	end

	// ==============================
	// Checking helpers
	// ==============================
	task automatic stop_with_failure();
		$display("SIMULATION FAILED");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [63:0] got,
			input logic [63:0] expected);
		assert (got === expected) else begin
			$display("mismatch at %0t ns: %s is %0h, expected %0h", $time, name, got, expected);
			stop_with_failure();
		end
	endtask

	always @(negedge clk_sys) begin
		if (bound_failures != 0) begin
			$display("A protocol assertion in the bound checker failed");
			stop_with_failure();
		end
	end

	function automatic logic probe(input int which);
		case (which)
			SIG_FILL:    probe = fill_wr;
			SIG_REQ:     probe = sd_rd | sd_wr;
			SIG_STROBE:  probe = code_strobe;
			default:     probe = bk_loading;
		endcase
	endfunction

	task automatic wait_level(input int which, input logic level, input int limit,
			input string what);
		int cycles;
		cycles = 0;
		while (probe(which) !== level) begin
			@(negedge clk_sys);
			cycles++;
			if (cycles > limit) begin
				$display("Timed out waiting for %s", what);
				stop_with_failure();
			end
		end
	endtask

	// Expected mask is 1 KiB shifted by the size code less one
	function automatic logic [63:0] mask_for_size(input int code);
		return (64'd1024 << code) - 64'd1;
	endfunction

	function automatic logic [7:0] expected_fill(input fill_pattern_e pattern, input int addr);
		if (pattern == fill_snes1) begin
			return (addr[9] != addr[0]) ? 8'hFF : 8'h00;
		end else if (pattern == fill_snes2) begin
			return (addr[8] != addr[2]) ? 8'h66 : 8'h99;
		end else if (pattern == fill_sd2snes) begin
			return 8'h55;
		end
		return 8'hFF;
	endfunction

	// ==============================
	// Stimulus helpers
	// ==============================
	task automatic set_download(input logic on, input logic [7:0] index);
		@(negedge clk_sys);
		ioctl_index    = index;
		ioctl_download = on;
	endtask

	task automatic write_word(input logic [IOCTL_ADDR_W-1:0] addr, input logic [15:0] data);
		@(negedge clk_sys);
		ioctl_addr = addr;
		ioctl_dout = data;
		ioctl_wr   = 1'b1;
		@(negedge clk_sys);
		ioctl_wr = 1'b0;
	endtask

	task automatic run_fill_sweep(input fill_pattern_e pattern);
		int count;
		wait_level(SIG_FILL, 1'b0, 2 * FILL_WORDS, "the previous fill sweep to end");
		fill_pattern = pattern;
		set_download(1'b1, 8'h00);
		set_download(1'b0, 8'h00);
		wait_level(SIG_FILL, 1'b1, 4, "fill_wr to rise");
		count = 0;
		while (fill_wr) begin
			check_value("fill_addr", fill_addr, count);
			check_value("fill_data", fill_data, expected_fill(pattern, count));
			check_value("system_reset", system_reset, 1'b1);
			count++;
			@(negedge clk_sys);
			if (count > FILL_WORDS) begin
				$display("fill_wr stayed high past the end of the sweep");
				stop_with_failure();
			end
		end
		check_value("fill write count", count, FILL_WORDS);
	endtask

	// Disk side acknowledges each sector after a random delay
	task automatic serve_sectors(input int count, input logic is_load);
		int lba;
		int delay;
		for (lba = 0; lba < count; lba++) begin
			wait_level(SIG_REQ, 1'b1, 64, "a sector request");
			check_value("sd_rd", sd_rd, is_load);
			check_value("sd_wr", sd_wr, !is_load);
			check_value("sd_lba", sd_lba, lba);
			if (is_load) begin
				check_value("bk_loading", bk_loading, 1'b1);
				check_value("system_reset", system_reset, 1'b1);
			end
			delay = 1 + ($unsigned($random(seed)) % 8);
			repeat (delay) @(negedge clk_sys);
			sd_ack = 1'b1;
			wait_level(SIG_REQ, 1'b0, 4, "the request to drop after sd_ack");
			sd_ack = 1'b0;
		end
	endtask

	// ==============================
	// Test sequence
	// ==============================
	initial begin
		int i;
		seed           = 32'hba2d4d59;
		RESET          = 1'b1;
		ioctl_download = 1'b0;
		ioctl_index    = 8'h00;
		ioctl_addr     = '0;
		ioctl_dout     = '0;
		ioctl_wr       = 1'b0;
		header_mode    = hdr_auto;
		region_select  = region_auto;
		fill_pattern   = fill_snes1;
		img_mounted    = 1'b0;
		img_readonly   = 1'b0;
		img_size       = 64'd0;
		bk_load_req    = 1'b0;
		bk_save_req    = 1'b0;
		autosave       = 1'b0;
		osd_status     = 1'b0;
		bsram_write    = 1'b0;
		sd_ack         = 1'b0;
		repeat (2) @(negedge clk_sys);
		RESET = 1'b0;

		// Auto header with packed size byte and region bit
		set_download(1'b1, 8'h00);
		write_word(25'd0, 16'h2031);
		write_word(25'd2, 16'h0100);
		check_value("rom_type", rom_type, 8'h20);
		check_value("rom_mask", rom_mask, mask_for_size(1));
		check_value("ram_mask", ram_mask, mask_for_size(3));
		set_download(1'b0, 8'h00);
		@(negedge clk_sys);
		check_value("pal", pal, 1'b1);
		region_select = region_ntsc;
		@(negedge clk_sys);
		check_value("pal", pal, 1'b0);
		region_select = region_auto;

		// Forced HiROM takes sizes from the header fields
		header_mode = hdr_hirom;
		set_download(1'b1, 8'h00);
		write_word(25'd0, 16'h2031);
		write_word(HIROM_INFO + HEADER_SKIP, 16'h35C0);
		// Packed size byte of word 0 gives way to the defaults
		check_value("rom_mask", rom_mask, mask_for_size(DEFAULT_ROM_SIZE));
		check_value("ram_mask", ram_mask, 64'd0);
		write_word(HIROM_INFO + HEADER_SKIP + 25'd2, 16'hC7E2);
		write_word(HIROM_INFO + HEADER_SKIP + 25'd4, 16'h0000);
		check_value("rom_type", rom_type, 8'h01);
		check_value("rom_mask", rom_mask, mask_for_size(5));
		check_value("ram_mask", ram_mask, mask_for_size(2));
		set_download(1'b0, 8'h00);
		header_mode = hdr_auto;

		run_fill_sweep(fill_snes1);
		run_fill_sweep(fill_snes2);

		// Cheat record of eight words
		set_download(1'b1, 8'hFF);
		for (i = 0; i < 8; i++) begin
			cheat_word[i] = 16'($random(seed));
			write_word(IOCTL_ADDR_W'(2 * i), cheat_word[i]);
		end
		wait_level(SIG_STROBE, 1'b1, 4, "code_strobe");
		check_value("code_flags", code_flags, {cheat_word[1], cheat_word[0]});
		check_value("code_addr", code_addr, {cheat_word[3], cheat_word[2]});
		check_value("code_compare", code_compare, {cheat_word[5], cheat_word[4]});
		check_value("code_replace", code_replace, {cheat_word[7], cheat_word[6]});
		set_download(1'b0, 8'hFF);

		// Autoload once a download with a writable image ends
		img_mounted = 1'b1;
		img_size    = 64'd8192;
		set_download(1'b1, 8'h00);
		write_word(25'd0, {8'h00, 4'(RAM_CODE), 4'h1});
		write_word(25'd2, 16'h0000);
		write_word(25'd4, 16'h0000);
		check_value("bk_ena", bk_ena, 1'b1);
		// Fill sweep ends first so only the load holds the core in reset
		wait_level(SIG_FILL, 1'b0, 2 * FILL_WORDS, "the fill sweep to end");
		set_download(1'b0, 8'h00);
		serve_sectors(2 << RAM_CODE, 1'b1);
		wait_level(SIG_LOADING, 1'b0, 4, "bk_loading to fall");
		check_value("system_reset", system_reset, 1'b0);

		// Manual save
		@(negedge clk_sys);
		bk_save_req = 1'b1;
		@(negedge clk_sys);
		bk_save_req = 1'b0;
		serve_sectors(2 << RAM_CODE, 1'b0);

		// Pending write, then autosave on menu open
		@(negedge clk_sys);
		autosave    = 1'b1;
		bsram_write = 1'b1;
		@(negedge clk_sys);
		bsram_write = 1'b0;
		check_value("bk_pending", bk_pending, 1'b1);
		osd_status = 1'b1;
		serve_sectors(2 << RAM_CODE, 1'b0);
		check_value("bk_pending", bk_pending, 1'b0);
		osd_status = 1'b0;
		autosave   = 1'b0;

		@(negedge clk_sys);
		if (bound_failures == 0) begin
			$display("SIMULATION PASSED");
			$finish;
		end else begin
			$display("A protocol assertion in the bound checker failed");
			stop_with_failure();
		end
	end

endmodule

//--- snes_loader_top.sv
`timescale 1ns/100ps

module snes_loader_top #(
	parameter int FILL_BITS = 17
) (
	input  logic                                     clk_sys,
	input  logic                                     RESET,
	input  logic                                     ioctl_download,
	input  logic [7:0]                               ioctl_index,
	input  logic [snes_loader_pkg::IOCTL_ADDR_W-1:0] ioctl_addr,
	input  logic [snes_loader_pkg::IOCTL_DATA_W-1:0] ioctl_dout,
	input  logic                                     ioctl_wr,
	input  snes_loader_pkg::header_mode_e            header_mode,
	input  snes_loader_pkg::region_e                 region_select,
	input  snes_loader_pkg::fill_pattern_e           fill_pattern,
	input  logic                                     img_mounted,
	input  logic                                     img_readonly,
	input  logic [63:0]                              img_size,
	input  logic                                     bk_load_req,
	input  logic                                     bk_save_req,
	input  logic                                     autosave,
	input  logic                                     osd_status,
	input  logic                                     bsram_write,
	input  logic                                     sd_ack,
	output logic [7:0]                               rom_type,
	output logic [snes_loader_pkg::MASK_W-1:0]       rom_mask,
	output logic [snes_loader_pkg::MASK_W-1:0]       ram_mask,
	output logic                                     pal,
	output logic [FILL_BITS-1:0]                     fill_addr,
	output logic [7:0]                               fill_data,
	output logic                                     fill_wr,
	output logic [31:0]                              code_flags,
	output logic [31:0]                              code_addr,
	output logic [31:0]                              code_compare,
	output logic [31:0]                              code_replace,
	output logic                                     code_strobe,
	output logic [snes_loader_pkg::LBA_W-1:0]        sd_lba,
	output logic                                     sd_rd,
	output logic                                     sd_wr,
	output logic                                     bk_ena,
	output logic                                     bk_loading,
	output logic                                     bk_pending,
	output logic                                     system_reset
);

	logic cart_download;
	logic code_download;
	logic cart_start;
	logic cart_end;

	// Core held in reset while the cartridge is loaded or RAM is prepared
	assign system_reset = RESET | cart_download | bk_loading | fill_wr;

	download_decoder download_decoder_inst (
		.clk_sys        (clk_sys),
		.RESET          (RESET),
		.ioctl_download (ioctl_download),
		.ioctl_index    (ioctl_index),
		.ioctl_addr     (ioctl_addr),
		.ioctl_dout     (ioctl_dout),
		.ioctl_wr       (ioctl_wr),
		.header_mode    (header_mode),
		.region_select  (region_select),
		.cart_download  (cart_download),
		.code_download  (code_download),
		.cart_start     (cart_start),
		.cart_end       (cart_end),
		.rom_type       (rom_type),
		.rom_mask       (rom_mask),
		.ram_mask       (ram_mask),
		.pal            (pal)
	);

	ram_clear_fill #(
		.FILL_BITS (FILL_BITS)
	) ram_clear_fill_inst (
		.clk_sys      (clk_sys),
		.RESET        (RESET),
		.cart_start   (cart_start),
		.fill_pattern (fill_pattern),
		.fill_addr    (fill_addr),
		.fill_data    (fill_data),
		.fill_wr      (fill_wr)
	);

	// Cheat records are 16 bytes so only the low address bits select a slot
	cheat_code_assembler cheat_code_assembler_inst (
		.clk_sys       (clk_sys),
		.RESET         (RESET),
		.code_download (code_download),
		.ioctl_wr      (ioctl_wr),
		.ioctl_addr    (ioctl_addr[3:0]),
		.ioctl_dout    (ioctl_dout),
		.code_flags    (code_flags),
		.code_addr     (code_addr),
		.code_compare  (code_compare),
		.code_replace  (code_replace),
		.code_strobe   (code_strobe)
	);

	backup_ram_sequencer backup_ram_sequencer_inst (
		.clk_sys       (clk_sys),
		.RESET         (RESET),
		.cart_download (cart_download),
		.cart_start    (cart_start),
		.cart_end      (cart_end),
		.ram_mask      (ram_mask),
		.img_mounted   (img_mounted),
		.img_readonly  (img_readonly),
		.img_size      (img_size),
		.bk_load_req   (bk_load_req),
		.bk_save_req   (bk_save_req),
		.autosave      (autosave),
		.osd_status    (osd_status),
		.bsram_write   (bsram_write),
		.sd_ack        (sd_ack),
		.sd_lba        (sd_lba),
		.sd_rd         (sd_rd),
		.sd_wr         (sd_wr),
		.bk_ena        (bk_ena),
		.bk_loading    (bk_loading),
		.bk_pending    (bk_pending)
	);

endmodule
